/* rtl/vid_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// image sizes are tiny on purpose and must stay a power of two in width
// ~~~~~~~~~~~~~~~~~~~~
package vid_pkg;

	// width of one colour channel as it leaves the chip
	localparam int COLOR_W = 6;

	// one stored image byte, packed as red 3, green 3, blue 2
	localparam int PIXEL_W = 8;

	// picture dimensions in pixels, one byte per pixel
	localparam int IMG_W = 16;
	localparam int IMG_H = 8;

	// total byte count of the image and so the video RAM depth
	localparam int IMG_SIZE = IMG_W * IMG_H;

	// address width needed to index every image byte
	localparam int IMG_ADDR_W = $clog2(IMG_SIZE);

	// the two frame formats differ only in their number of lines
	typedef enum logic {
		MODE_NTSC = 1'b0,
		MODE_PAL  = 1'b1
	} video_mode_t;

	// loader state, the copy runs exactly once per reset
	typedef enum logic {
		LOAD_COPYING = 1'b0,
		LOAD_DONE    = 1'b1
	} load_state_t;

	// tells a channel shader which field of the 3-3-2 byte it carries
	// red and green fields are 3 bits wide, blue is only 2
	typedef enum logic [1:0] {
		CHAN_R = 2'd0,
		CHAN_G = 2'd1,
		CHAN_B = 2'd2
	} chan_sel_t;

endpackage

/* rtl/image_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~
// accepts exactly IMG_SIZE bytes after reset, later strobes are dropped
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module image_loader (
	input  logic                           vga_clock,
	input  logic                           reset,
	input  logic                           load_strobe,
	input  logic [vid_pkg::PIXEL_W-1:0]    load_data,
	output logic                           wr_en,
	output logic [vid_pkg::IMG_ADDR_W-1:0] wr_addr,
	output logic [vid_pkg::PIXEL_W-1:0]    wr_data,
	output logic                           load_done
);
	import vid_pkg::*;

	load_state_t           state;
	logic [IMG_ADDR_W-1:0] addr;

	// a strobe is only honoured while the copy is still running
	assign wr_en = load_strobe && (state == LOAD_COPYING);

	// the byte goes straight to the RAM and lands on the next edge
	assign wr_addr = addr;
	assign wr_data = load_data;

	assign load_done = (state == LOAD_DONE);

	// address advances once per accepted byte
	// the last address moves the machine to done where it then stays
	always_ff @(posedge vga_clock) begin
		if (reset) begin
			state <= LOAD_COPYING;
			addr <= '0;
		end else if (wr_en) begin
			addr <= addr + 1'b1;
			if (addr == IMG_ADDR_W'(IMG_SIZE - 1))
				state <= LOAD_DONE;
		end
	end

	// done is only ever reached through the write to the last image address
	a_done_after_last: assert property (@(posedge vga_clock) disable iff (reset)
		$rose(load_done) |-> $past(wr_en && wr_addr == IMG_ADDR_W'(IMG_SIZE - 1)));

endmodule

/* rtl/video_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~
// pixel rate is half of vga_clock, syncs are active low
// h_w and v_w must be wide enough for h_total and the PAL frame length
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module video_timing #(
	parameter int h_active     = 16,
	parameter int h_front      = 2,
	parameter int h_sync       = 4,
	parameter int h_back       = 2,
	parameter int v_active     = 8,
	parameter int v_sync_start = 9,
	parameter int v_sync       = 2,
	parameter int v_total_ntsc = 12,
	parameter int v_total_pal  = 14,
	parameter int h_w          = 5,
	parameter int v_w          = 4
) (
	input  logic                 vga_clock,
	input  logic                 reset,
	input  vid_pkg::video_mode_t mode,
	output logic                 pix_en,
	output logic [h_w-1:0]       h_count,
	output logic [v_w-1:0]       v_count,
	output logic                 active,
	output logic                 hs,
	output logic                 vs
);
	import vid_pkg::*;

	localparam int h_total = h_active + h_front + h_sync + h_back;

	// sync window on the horizontal counter
	localparam int hs_first = h_active + h_front;
	localparam int hs_last  = h_active + h_front + h_sync - 1;

	logic [v_w-1:0] v_last;
	logic           h_wrap;

	// PAL simply adds lines to the bottom of the frame
	assign v_last = (mode == MODE_PAL) ? v_w'(v_total_pal - 1) : v_w'(v_total_ntsc - 1);

	assign h_wrap = (h_count == h_w'(h_total - 1));

	// half rate enable, low in the first cycle after reset
	always_ff @(posedge vga_clock) begin
		if (reset)
			pix_en <= 1'b0;
		else
			pix_en <= !pix_en;
	end

	// counters step once per pixel
	// a mode change mid frame is caught by the >= compare on the line count
	always_ff @(posedge vga_clock) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (pix_en) begin
			if (h_wrap) begin
				h_count <= '0;
				if (v_count >= v_last)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	// decodes straight from the counters, the output stage registers them
	assign active = (h_count < h_w'(h_active)) && (v_count < v_w'(v_active));
	assign hs = !((h_count >= h_w'(hs_first)) && (h_count <= h_w'(hs_last)));
	assign vs = !((v_count >= v_w'(v_sync_start)) &&
		(v_count < v_w'(v_sync_start + v_sync)));

	a_h_in_range: assert property (@(posedge vga_clock) disable iff (reset)
		h_count < h_w'(h_total));

	// the line counter only moves on the last pixel of a line
	a_v_steps_at_wrap: assert property (@(posedge vga_clock) disable iff (reset)
		!(pix_en && h_wrap) |=> $stable(v_count));

endmodule

/* rtl/pixel_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// RAM contents are undefined until the loader has written them
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pixel_fetch #(
	parameter int h_w = 5,
	parameter int v_w = 4
) (
	input  logic                           vga_clock,
	input  logic                           reset,
	input  logic                           wr_en,
	input  logic [vid_pkg::IMG_ADDR_W-1:0] wr_addr,
	input  logic [vid_pkg::PIXEL_W-1:0]    wr_data,
	input  logic                           pix_en,
	input  logic [h_w-1:0]                 h_count,
	input  logic [v_w-1:0]                 v_count,
	input  logic                           active,
	output logic [2:0]                     red_field,
	output logic [2:0]                     green_field,
	output logic [1:0]                     blue_field,
	output logic                           active_d,
	output logic                           odd_line
);
	import vid_pkg::*;

	logic [PIXEL_W-1:0]    vram [IMG_SIZE];
	logic [PIXEL_W-1:0]    pixel;
	logic [IMG_ADDR_W-1:0] rd_addr;

	// loader port, one byte per accepted strobe
	always_ff @(posedge vga_clock) begin
		if (wr_en)
			vram[wr_addr] <= wr_data;
	end

	// row major layout, the image is stored line after line
	// outside the picture the address wraps but the pixel gets blanked anyway
	assign rd_addr = IMG_ADDR_W'(v_count * IMG_W + h_count);

	// first pipeline stage, the RAM read itself
	always_ff @(posedge vga_clock) begin
		if (pix_en)
			pixel <= vram[rd_addr];
	end

	// the flags follow the byte so the shader sees them on the same pixel
	always_ff @(posedge vga_clock) begin
		if (reset) begin
			active_d <= 1'b0;
			odd_line <= 1'b0;
		end else if (pix_en) begin
			active_d <= active;
			odd_line <= v_count[0];
		end
	end

	// split the 3-3-2 byte, red sits in the top bits
	assign red_field   = pixel[7:5];
	assign green_field = pixel[4:2];
	assign blue_field  = pixel[1:0];

endmodule

/* rtl/channel_shade.sv */
// ~~~~~~~~~~~~~~~~~~~~
// blue uses only the low two bits of field
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module channel_shade #(
	parameter vid_pkg::chan_sel_t chan_sel = vid_pkg::CHAN_R
) (
	input  logic                        vga_clock,
	input  logic                        reset,
	input  logic                        pix_en,
	input  logic [2:0]                  field,
	input  logic                        active_d,
	input  logic                        odd_line,
	input  logic                        scanlines,
	output logic [vid_pkg::COLOR_W-1:0] level
);
	import vid_pkg::*;

	logic [COLOR_W-1:0] expanded;
	logic [COLOR_W-1:0] shaded;

	// widen by repeating the field so full scale maps to full scale
	always_comb begin
		case (chan_sel)
			CHAN_B:  expanded = {3{field[1:0]}};
			default: expanded = {2{field}};
		endcase
	end

	// odd lines at half brightness give the scanline look
	assign shaded = (scanlines && odd_line) ? (expanded >> 1) : expanded;

	// second pipeline stage, blanking happens here
	always_ff @(posedge vga_clock) begin
		if (reset)
			level <= '0;
		else if (pix_en)
			level <= active_d ? shaded : '0;
	end

endmodule

/* rtl/sync_output.sv */
// ~~~~~~~~~~~~~~~~~~~~
// outputs change only on pixel enable, pixel_ce marks the new value
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sync_output (
	input  logic                        vga_clock,
	input  logic                        reset,
	input  logic                        pix_en,
	input  logic                        hs,
	input  logic                        vs,
	input  logic                        active,
	input  logic [vid_pkg::COLOR_W-1:0] level_r,
	input  logic [vid_pkg::COLOR_W-1:0] level_g,
	input  logic [vid_pkg::COLOR_W-1:0] level_b,
	output logic                        pixel_ce,
	output logic                        vga_hs,
	output logic                        vga_vs,
	output logic                        vga_de,
	output logic [vid_pkg::COLOR_W-1:0] vga_r,
	output logic [vid_pkg::COLOR_W-1:0] vga_g,
	output logic [vid_pkg::COLOR_W-1:0] vga_b
);
	import vid_pkg::*;

	// two stages stand in for the fetch and the shade registers
	logic [1:0] hs_d;
	logic [1:0] vs_d;
	logic [1:0] active_dly;

	// syncs idle high, so reset fills their shift with ones
	always_ff @(posedge vga_clock) begin
		if (reset) begin
			hs_d <= 2'b11;
			vs_d <= 2'b11;
			active_dly <= 2'b00;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_de <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (pix_en) begin
			hs_d <= {hs_d[0], hs};
			vs_d <= {vs_d[0], vs};
			active_dly <= {active_dly[0], active};
			// third stage, everything leaves here for the same pixel
			vga_hs <= hs_d[1];
			vga_vs <= vs_d[1];
			vga_de <= active_dly[1];
			vga_r <= level_r;
			vga_g <= level_g;
			vga_b <= level_b;
		end
	end

	// high in the cycle right after the outputs took a new pixel
	always_ff @(posedge vga_clock) begin
		if (reset)
			pixel_ce <= 1'b0;
		else
			pixel_ce <= pix_en;
	end

endmodule

/* rtl/vid_test_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// video runs freely from reset, the image shows once load_done is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module vid_test_top #(
	parameter int h_active     = 16,
	parameter int h_front      = 2,
	parameter int h_sync       = 4,
	parameter int h_back       = 2,
	parameter int v_active     = 8,
	parameter int v_sync_start = 9,
	parameter int v_sync       = 2,
	parameter int v_total_ntsc = 12,
	parameter int v_total_pal  = 14
) (
	input  logic                        vga_clock,
	input  logic                        reset,
	input  logic                        load_strobe,
	input  logic [vid_pkg::PIXEL_W-1:0] load_data,
	input  logic                        scanlines,
	input  logic                        pal,
	output logic                        load_done,
	output logic                        pixel_ce,
	output logic                        vga_hs,
	output logic                        vga_vs,
	output logic                        vga_de,
	output logic [vid_pkg::COLOR_W-1:0] vga_r,
	output logic [vid_pkg::COLOR_W-1:0] vga_g,
	output logic [vid_pkg::COLOR_W-1:0] vga_b
);
	import vid_pkg::*;

	// counter widths, the PAL frame is the longer one
	localparam int h_w = $clog2(h_active + h_front + h_sync + h_back);
	localparam int v_w = $clog2(v_total_pal);

	logic                  wr_en;
	logic [IMG_ADDR_W-1:0] wr_addr;
	logic [PIXEL_W-1:0]    wr_data;
	video_mode_t           mode;
	logic                  pix_en;
	logic [h_w-1:0]        h_count;
	logic [v_w-1:0]        v_count;
	logic                  active;
	logic                  hs;
	logic                  vs;
	logic [2:0]            red_field;
	logic [2:0]            green_field;
	logic [1:0]            blue_field;
	logic                  active_d;
	logic                  odd_line;

	// indexed by chan_sel_t so the generate loop can pick its own entry
	logic [2:0]         field_by_chan [3];
	logic [COLOR_W-1:0] level_by_chan [3];

	assign mode = pal ? MODE_PAL : MODE_NTSC;

	image_loader u_loader (
		.vga_clock   (vga_clock),
		.reset       (reset),
		.load_strobe (load_strobe),
		.load_data   (load_data),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.load_done   (load_done)
	);

	video_timing #(
		.h_active     (h_active),
		.h_front      (h_front),
		.h_sync       (h_sync),
		.h_back       (h_back),
		.v_active     (v_active),
		.v_sync_start (v_sync_start),
		.v_sync       (v_sync),
		.v_total_ntsc (v_total_ntsc),
		.v_total_pal  (v_total_pal),
		.h_w          (h_w),
		.v_w          (v_w)
	) u_timing (
		.vga_clock (vga_clock),
		.reset     (reset),
		.mode      (mode),
		.pix_en    (pix_en),
		.h_count   (h_count),
		.v_count   (v_count),
		.active    (active),
		.hs        (hs),
		.vs        (vs)
	);

	pixel_fetch #(
		.h_w (h_w),
		.v_w (v_w)
	) u_fetch (
		.vga_clock   (vga_clock),
		.reset       (reset),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.pix_en      (pix_en),
		.h_count     (h_count),
		.v_count     (v_count),
		.active      (active),
		.red_field   (red_field),
		.green_field (green_field),
		.blue_field  (blue_field),
		.active_d    (active_d),
		.odd_line    (odd_line)
	);

	// blue travels in the low bits of a 3 bit field
	assign field_by_chan[CHAN_R] = red_field;
	assign field_by_chan[CHAN_G] = green_field;
	assign field_by_chan[CHAN_B] = {1'b0, blue_field};

	for (genvar i = 0; i < 3; i++) begin : g_chan
		channel_shade #(
			.chan_sel (chan_sel_t'(i))
		) u_shade (
			.vga_clock (vga_clock),
			.reset     (reset),
			.pix_en    (pix_en),
			.field     (field_by_chan[i]),
			.active_d  (active_d),
			.odd_line  (odd_line),
			.scanlines (scanlines),
			.level     (level_by_chan[i])
		);
	end

	sync_output u_out (
		.vga_clock (vga_clock),
		.reset     (reset),
		.pix_en    (pix_en),
		.hs        (hs),
		.vs        (vs),
		.active    (active),
		.level_r   (level_by_chan[CHAN_R]),
		.level_g   (level_by_chan[CHAN_G]),
		.level_b   (level_by_chan[CHAN_B]),
		.pixel_ce  (pixel_ce),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs),
		.vga_de    (vga_de),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b)
	);

endmodule

/* test/tb_vid_test.sv */
// ~~~~~~~~~~~~~~~~~~~~
// loads the image first, frame lengths assume the default raster of vid_test_top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_vid_test;
	import vid_pkg::*;

	localparam int clk_period = 4;
	localparam int reset_cycles = 10;
	localparam int extra_strobes = 8;
	localparam int frames_per_row = 2;
	localparam int mode_rows = 4;
	// longest frame is PAL with 14 lines of 24 pixels at two clocks per pixel
	localparam int frame_cycles = 14 * 24 * 2;
	// one frame to find the frame start, one spare, then the checked frames
	localparam int run_cycles = reset_cycles + IMG_SIZE + extra_strobes +
		mode_rows * (frames_per_row + 2) * frame_cycles;

	logic               vga_clock;
	logic               reset;
	logic               load_strobe;
	logic [PIXEL_W-1:0] load_data;
	logic               scanlines;
	logic               pal;
	logic               load_done;
	logic               pixel_ce;
	logic               vga_hs;
	logic               vga_vs;
	logic               vga_de;
	logic [COLOR_W-1:0] vga_r;
	logic [COLOR_W-1:0] vga_g;
	logic [COLOR_W-1:0] vga_b;

	logic [PIXEL_W-1:0] image [IMG_SIZE];
	integer             seed = 32'h7531_ea66;
	int                 err_count = 0;
	logic               prev_hs;
	logic               prev_vs;

	// each row holds scanlines, pal and the expected hsync count per frame
	int mode_table [mode_rows][3] = '{'{0, 0, 12}, '{1, 0, 12}, '{0, 1, 14}, '{1, 1, 14}};

	vid_test_top DUT (
		.vga_clock   (vga_clock),
		.reset       (reset),
		.load_strobe (load_strobe),
		.load_data   (load_data),
		.scanlines   (scanlines),
		.pal         (pal),
		.load_done   (load_done),
		.pixel_ce    (pixel_ce),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_de      (vga_de),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b)
	);

	initial begin
		vga_clock = 1'b0;
		forever #(clk_period / 2) vga_clock = ~vga_clock;
	end

	// the run can never take twice the budget of all loads and frames
	initial begin
		#(2 * run_cycles * clk_period);
		$display("timeout, the video frames did not arrive in the expected time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// 3-3-2 expansion by repetition, with the scanline halving on top
	function automatic logic [COLOR_W-1:0] expected_level(input logic [PIXEL_W-1:0] pixel,
		input int chan, input logic half);
		logic [COLOR_W-1:0] value;
		case (chan)
			0:       value = {pixel[7:5], pixel[7:5]};
			1:       value = {pixel[4:2], pixel[4:2]};
			default: value = {pixel[1:0], pixel[1:0], pixel[1:0]};
		endcase
		if (half)
			value = value >> 1;
		return value;
	endfunction

	// outputs are stable at the falling edge while pixel_ce is high
	task automatic next_pixel();
		prev_hs = vga_hs;
		prev_vs = vga_vs;
		@(negedge vga_clock);
		while (pixel_ce !== 1'b1)
			@(negedge vga_clock);
	endtask

	task automatic wait_frame_start();
		next_pixel();
		while (!(prev_vs && !vga_vs))
			next_pixel();
	endtask

	// walks one frame from a vsync falling edge up to the next one
	task automatic check_frame(input logic scan, input int exp_lines);
		int                 line;
		int                 col;
		int                 hs_falls;
		logic               in_line;
		logic               half;
		logic [PIXEL_W-1:0] pixel;
		line = 0;
		col = 0;
		hs_falls = 0;
		in_line = 1'b0;
		next_pixel();
		while (!(prev_vs && !vga_vs)) begin
			if (prev_hs && !vga_hs)
				hs_falls++;
			if (vga_de) begin
				// position is tracked only by counting enabled samples
				check_value("vga_de within image lines", 32'(line < IMG_H), 1);
				check_value("vga_de within image columns", 32'(col < IMG_W), 1);
				pixel = image[line * IMG_W + col];
				half = scan && line[0];
				check_value($sformatf("vga_r line %0d col %0d", line, col), 32'(vga_r),
					32'(expected_level(pixel, 0, half)));
				check_value($sformatf("vga_g line %0d col %0d", line, col), 32'(vga_g),
					32'(expected_level(pixel, 1, half)));
				check_value($sformatf("vga_b line %0d col %0d", line, col), 32'(vga_b),
					32'(expected_level(pixel, 2, half)));
				col++;
				in_line = 1'b1;
			end else begin
				// blanking keeps every colour at zero
				check_value("vga_r blanked", 32'(vga_r), 0);
				check_value("vga_g blanked", 32'(vga_g), 0);
				check_value("vga_b blanked", 32'(vga_b), 0);
				if (in_line) begin
					check_value("vga_de pixels per line", 32'(col), IMG_W);
					line++;
					col = 0;
					in_line = 1'b0;
				end
			end
			next_pixel();
		end
		check_value("vga_de lines per frame", 32'(line), IMG_H);
		check_value("vga_hs falls per frame", 32'(hs_falls), 32'(exp_lines));
	endtask

	initial begin
		reset = 1'b1;
		load_strobe = 1'b0;
		load_data = '0;
		scanlines = 1'b0;
		pal = 1'b0;
		for (int k = 0; k < IMG_SIZE; k++)
			image[k] = PIXEL_W'($random(seed));

		repeat (reset_cycles) @(negedge vga_clock);
		reset = 1'b0;

		// nothing loaded yet and the outputs still show their idle levels
		check_value("load_done", 32'(load_done), 0);
		check_value("vga_de", 32'(vga_de), 0);
		check_value("vga_hs", 32'(vga_hs), 1);
		check_value("vga_vs", 32'(vga_vs), 1);
		check_value("pixel_ce", 32'(pixel_ce), 0);
		check_value("vga_r", 32'(vga_r), 0);
		check_value("vga_g", 32'(vga_g), 0);
		check_value("vga_b", 32'(vga_b), 0);

		// one byte per cycle, load_done must wait for the last one
		for (int k = 0; k < IMG_SIZE; k++) begin
			check_value("load_done", 32'(load_done), 0);
			load_strobe = 1'b1;
			load_data = image[k];
			@(negedge vga_clock);
		end
		load_strobe = 1'b0;
		check_value("load_done", 32'(load_done), 1);

		// late strobes carry inverted data that must never reach the screen
		for (int k = 0; k < extra_strobes; k++) begin
			load_strobe = 1'b1;
			load_data = ~image[k];
			@(negedge vga_clock);
			check_value("load_done", 32'(load_done), 1);
		end
		load_strobe = 1'b0;

		for (int row = 0; row < mode_rows; row++) begin
			scanlines = (mode_table[row][0] != 0);
			pal = (mode_table[row][1] != 0);
			// the frame after the next vsync edge runs fully in the new mode
			wait_frame_start();
			repeat (frames_per_row)
				check_frame(scanlines, mode_table[row][2]);
		end

		if (err_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "checks reported errors");
		end
	end

endmodule

/* src.f */
rtl/vid_pkg.sv
rtl/image_loader.sv
rtl/video_timing.sv
rtl/pixel_fetch.sv
rtl/channel_shade.sv
rtl/sync_output.sv
rtl/vid_test_top.sv
test/tb_vid_test.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_vid_test
FILELIST  = src.f
PASS_MSG  = ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
